// ==== fpClass.f ====
+incdir+.
fpClassPkg.sv
fpDecompIf.sv
fpDecompReg.sv
fpCompare.sv
fpApbRegs.sv
fpClassTop.sv
tbFpClassTop.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the fpClass testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fpClass.f --top-module tbFpClassTop
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/VtbFpClassTop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tbFpClassTop.sv ====
// ==============================
// testbench for fpClassTop
// directed APB tests of classify,
// compare and bus errors, plus
// random pairs against a model
// ==============================
`timescale 1ns/1ps
`include "fpClass_defines.svh"

module tbFpClassTop;

	localparam int NUM_TESTS  = 6;
	localparam int TIMEOUT_NS = NUM_TESTS * 200 * 40 * 20;  // tests x ops x cycles x period

	logic               clk;
	logic               reset;
	fpClassPkg::apbAddr paddr;
	logic               psel;
	logic               penable;
	logic               pwrite;
	fpClassPkg::fpWord  pwdata;
	fpClassPkg::fpWord  prdata;
	logic               pready;
	logic               pslverr;

	int          errorCount;
	int          errorsAtStart;  // errors before the running test
	int          testsFailed;
	int          checkCount;

	fpClassTop fpClassTop_inst (
		.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	always #10 clk = ~clk;  // 20 ns period

	// ==============================
	// reference model
	// ==============================
	function automatic fpClassPkg::apbAddr addrOf(input fpClassPkg::regSel s);
		case (s)
			fpClassPkg::selOpA:    return `REG_OPA;
			fpClassPkg::selOpB:    return `REG_OPB;
			fpClassPkg::selCtrl:   return `REG_CTRL;
			fpClassPkg::selClassA: return `REG_CLASSA;
			fpClassPkg::selClassB: return `REG_CLASSB;
			fpClassPkg::selStatus: return `REG_STATUS;
			default:               return 5'h18;  // first offset past the map
		endcase
	endfunction

	function automatic logic isNan(input fpClassPkg::fpWord w);
		return (w[30:23] == 8'hFF) && (w[22:0] != 0);  // max exponent and fraction set
	endfunction

	// signed classes mirror around bits 3 and 4 with rank k counting outward
	function automatic fpClassPkg::fpClass refClass(input fpClassPkg::fpWord w);
		fpClassPkg::fpClass c;
		int                 k;
		c = '0;
		if (isNan(w)) begin
			c[w[22] ? 9 : 8] = 1'b1;
			return c;
		end
		if (w[30:0] == 0)
			k = 0;                   // zero
		else if (w[30:23] == 0)
			k = 1;                   // subnormal
		else if (w[30:23] == 8'hFF)
			k = 3;                   // infinity
		else
			k = 2;                   // normal
		c[w[31] ? 3 - k : 4 + k] = 1'b1;
		return c;
	endfunction

	// monotonic unsigned key where both zeros share one key
	function automatic logic [31:0] orderKey(input fpClassPkg::fpWord w);
		if (w[30:0] == 0)
			return 32'h8000_0000;
		return w[31] ? ~w : (w | 32'h8000_0000);
	endfunction

	// {invalid, unordered, lt, eq} in STATUS[4:1] order
	function automatic logic [3:0] refFlags(input fpClassPkg::fpWord a,
			input fpClassPkg::fpWord b);
		logic sigNan;
		sigNan = (isNan(a) && !a[22]) || (isNan(b) && !b[22]);
		if (isNan(a) || isNan(b))
			return {sigNan, 1'b1, 2'b00};
		return {2'b00, orderKey(a) < orderKey(b), orderKey(a) == orderKey(b)};
	endfunction

	// ==============================
	// checks
	// ==============================
	task automatic checkWord(input string name, input fpClassPkg::fpWord expected,
			input fpClassPkg::fpWord actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkClass(input string name, input fpClassPkg::fpClass expected,
			input fpClassPkg::fpClass actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkFlags(input string name, input logic [3:0] expected,
			input logic [3:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// ==============================
	// APB driver
	// ==============================
	// entered and left 1 ns after a rising edge
	task automatic apbAccess(input fpClassPkg::apbAddr addr, input logic write,
			input fpClassPkg::fpWord wdata, output fpClassPkg::fpWord rdata, output logic err);
		paddr   = addr;  // setup phase
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1 penable = 1'b1;
		#2;  // let the access phase settle
		if (pready !== 1'b1) begin
			errorCount++;
			$display("pready was low during an access phase at %0t ns", $time);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbWrite(input fpClassPkg::apbAddr addr, input fpClassPkg::fpWord data,
			output logic err);
		fpClassPkg::fpWord unused;
		apbAccess(addr, 1'b1, data, unused, err);
	endtask

	task automatic apbRead(input fpClassPkg::apbAddr addr, output fpClassPkg::fpWord data,
			output logic err);
		apbAccess(addr, 1'b0, '0, data, err);
	endtask

	// load operands, start, poll done, then fetch the results
	task automatic runOp(input fpClassPkg::fpWord a, input fpClassPkg::fpWord b,
			output fpClassPkg::fpClass clsA, output fpClassPkg::fpClass clsB,
			output logic [3:0] flags);
		fpClassPkg::fpWord status;
		fpClassPkg::fpWord rd;
		logic              err;
		int                polls;
		apbWrite(addrOf(fpClassPkg::selOpA), a, err);
		apbWrite(addrOf(fpClassPkg::selOpB), b, err);
		apbWrite(addrOf(fpClassPkg::selCtrl), 32'h1, err);
		status = '0;
		polls  = 0;
		while (!status[0] && polls < 10) begin
			apbRead(addrOf(fpClassPkg::selStatus), status, err);
			polls++;
		end
		if (!status[0]) begin
			errorCount++;
			$display("operation on %h and %h never reported done within 10 status reads", a, b);
		end
		apbRead(addrOf(fpClassPkg::selClassA), rd, err);
		clsA = rd[`CLASS_WIDTH-1:0];
		apbRead(addrOf(fpClassPkg::selClassB), rd, err);
		clsB  = rd[`CLASS_WIDTH-1:0];
		flags = status[4:1];
	endtask

	task automatic checkOp(input fpClassPkg::fpWord a, input fpClassPkg::fpWord b);
		fpClassPkg::fpClass clsA;
		fpClassPkg::fpClass clsB;
		logic [3:0]         flags;
		runOp(a, b, clsA, clsB, flags);
		checkClass("classA", refClass(a), clsA);
		checkClass("classB", refClass(b), clsB);
		checkFlags("status flags", refFlags(a, b), flags);
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic resetAndReadback();
		fpClassPkg::regSel s;
		fpClassPkg::fpWord rd;
		logic              err;
		for (int k = 0; k < 6; k++) begin
			s = fpClassPkg::regSel'(k);
			apbRead(addrOf(s), rd, err);
			checkWord(s.name(), '0, rd);
			checkBit("pslverr", 1'b0, err);
		end
		apbWrite(addrOf(fpClassPkg::selOpA), 32'h3F80_0000, err);
		apbWrite(addrOf(fpClassPkg::selOpB), 32'hC049_0FDB, err);
		apbRead(addrOf(fpClassPkg::selOpA), rd, err);
		checkWord("opA readback", 32'h3F80_0000, rd);
		apbRead(addrOf(fpClassPkg::selOpB), rd, err);
		checkWord("opB readback", 32'hC049_0FDB, rd);
	endtask

	task automatic classifyTenValues();
		fpClassPkg::fpWord  vals [10] = '{32'h0000_0000, 32'h8000_0000, 32'h0000_0001,
			32'h8000_0001, 32'h3F80_0000, 32'hBF80_0000, 32'h7F80_0000, 32'hFF80_0000,
			32'h7FC0_0000, 32'h7F80_0001};
		int                 bitIdx [10] = '{4, 3, 5, 2, 6, 1, 7, 0, 9, 8};
		fpClassPkg::fpClass clsA;
		fpClassPkg::fpClass clsB;
		logic [3:0]         flags;
		for (int k = 0; k < 10; k += 2) begin
			runOp(vals[k], vals[k+1], clsA, clsB, flags);
			checkClass("classA", fpClassPkg::fpClass'(1) << bitIdx[k], clsA);
			checkClass("classB", fpClassPkg::fpClass'(1) << bitIdx[k+1], clsB);
		end
	endtask

	task automatic compareOrderedPairs();
		checkOp(32'h3F80_0000, 32'h3F80_0000);  // 1.0 == 1.0
		checkOp(32'h0000_0000, 32'h8000_0000);  // +0 == -0
		checkOp(32'hC000_0000, 32'h3F80_0000);  // -2 < 1
		checkOp(32'hC000_0000, 32'hBF80_0000);  // -2 < -1
		checkOp(32'hBF80_0000, 32'hC000_0000);
		checkOp(32'h0000_0001, 32'h3F80_0000);  // subnormal vs normal
		checkOp(32'h3F80_0000, 32'h0000_0001);
	endtask

	task automatic handleNans();
		checkOp(32'h7FC0_0000, 32'h3F80_0000);  // quiet NaN is not invalid
		checkOp(32'h3F80_0000, 32'h7F80_0001);  // signalling
		checkOp(32'hFFC0_0000, 32'hFF80_0001);
		checkOp(32'h7FC0_0000, 32'h7FC0_0000);  // equal bits still unordered
	endtask

	task automatic rejectBadAccesses();
		fpClassPkg::fpWord classBefore;
		fpClassPkg::fpWord statusBefore;
		fpClassPkg::fpWord rd;
		logic              err;
		checkOp(32'h3F80_0000, 32'h4000_0000);
		apbRead(addrOf(fpClassPkg::selClassA), classBefore, err);
		apbRead(addrOf(fpClassPkg::selStatus), statusBefore, err);
		apbWrite(addrOf(fpClassPkg::selNone), 32'hFFFF_FFFF, err);
		checkBit("pslverr unmapped write", 1'b1, err);
		apbWrite(5'h01, 32'hFFFF_FFFF, err);                          // unaligned
		checkBit("pslverr unaligned write", 1'b1, err);
		apbWrite(addrOf(fpClassPkg::selClassA), 32'h0000_03FF, err);
		checkBit("pslverr classA write", 1'b1, err);
		apbWrite(addrOf(fpClassPkg::selStatus), 32'h0000_001F, err);
		checkBit("pslverr status write", 1'b1, err);
		apbRead(5'h1C, rd, err);
		checkBit("pslverr unmapped read", 1'b1, err);
		apbRead(addrOf(fpClassPkg::selOpA), rd, err);
		checkWord("opA after bad writes", 32'h3F80_0000, rd);
		apbRead(addrOf(fpClassPkg::selOpB), rd, err);
		checkWord("opB after bad writes", 32'h4000_0000, rd);
		apbRead(addrOf(fpClassPkg::selClassA), rd, err);
		checkWord("classA after bad writes", classBefore, rd);
		apbRead(addrOf(fpClassPkg::selStatus), rd, err);
		checkWord("status after bad writes", statusBefore, rd);
	endtask

	// random word whose exponent is pushed to 0 or 255 half the time
	function automatic fpClassPkg::fpWord randOperand();
		fpClassPkg::fpWord w;
		w = $urandom;
		case ($urandom % 4)
			0: w[30:23] = 8'h00;
			1: w[30:23] = 8'hFF;
			default: ;
		endcase
		return w;
	endfunction

	task automatic randomPairs();
		fpClassPkg::fpWord a;
		fpClassPkg::fpWord b;
		for (int n = 0; n < 200; n++) begin
			a = randOperand();
			case ($urandom % 8)
				0: b = a;                   // hits eq
				1: b = a ^ 32'h8000_0000;  // same magnitude and other sign
				default: b = randOperand();
			endcase
			checkOp(a, b);
		end
	endtask

	task automatic reportTest(input int num, input string name);
		if (errorCount == errorsAtStart) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", num, name,
				errorCount - errorsAtStart);
		end
		errorsAtStart = errorCount;
	endtask

	// ==============================
	// main sequence and watchdog
	// ==============================
	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		paddr         = '0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		pwdata        = '0;
		errorCount    = 0;
		errorsAtStart = 0;
		testsFailed   = 0;
		checkCount    = 0;
		void'($urandom(63585));
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		resetAndReadback();
		reportTest(1, "reset values and operand readback");
		classifyTenValues();
		reportTest(2, "ten classes");
		compareOrderedPairs();
		reportTest(3, "ordered compare");
		handleNans();
		reportTest(4, "NaN compare");
		rejectBadAccesses();
		reportTest(5, "bus errors");
		randomPairs();
		reportTest(6, "random pairs");
		$display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog stopped the run after %0d ns, the tests did not finish", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== fpClassTop.sv ====
// ==============================
// fp classify/compare unit top
// APB registers feeding two
// decomposition stages and the
// classify/compare stage
// ==============================
`timescale 1ns/1ps

module fpClassTop (
	input  logic               clk,
	input  logic               reset,
	input  fpClassPkg::apbAddr paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  fpClassPkg::fpWord  pwdata,
	output fpClassPkg::fpWord  prdata,
	output logic               pready,
	output logic               pslverr
);

	fpClassPkg::fpWord  opA;
	fpClassPkg::fpWord  opB;
	logic               start;
	logic               startD;     // start aligned with the decomposed operands
	fpClassPkg::fpClass classA;
	fpClassPkg::fpClass classB;
	logic               eq;
	logic               lt;
	logic               unordered;
	logic               invalid;
	logic               resultValid;

	fpDecompIf decA ();
	fpDecompIf decB ();

	// decomposition adds one cycle so the valid pulse follows it
	always_ff @(posedge clk) begin
		if (reset)
			startD <= 1'b0;
		else
			startD <= start;
	end

	fpApbRegs regsInst (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.opA(opA), .opB(opB), .start(start),
		.classA(classA), .classB(classB),
		.eq(eq), .lt(lt), .unordered(unordered), .invalid(invalid),
		.resultValid(resultValid)
	);

	fpDecompReg decRegA (.clk(clk), .reset(reset), .ce(start), .i(opA), .dec(decA));
	fpDecompReg decRegB (.clk(clk), .reset(reset), .ce(start), .i(opB), .dec(decB));

	fpCompare compareInst (
		.clk(clk), .reset(reset), .startIn(startD),
		.a(decA), .b(decB),
		.classA(classA), .classB(classB),
		.eq(eq), .lt(lt), .unordered(unordered), .invalid(invalid),
		.resultValid(resultValid)
	);

endmodule

// ==== fpApbRegs.sv ====
// ==============================
// APB register block
// operand, control, class and
// status registers, launches the
// classify pipeline, no wait states
// ==============================
`timescale 1ns/1ps
`include "fpClass_defines.svh"

module fpApbRegs (
	input  logic               clk,
	input  logic               reset,
	input  fpClassPkg::apbAddr paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  fpClassPkg::fpWord  pwdata,
	output fpClassPkg::fpWord  prdata,
	output logic               pready,
	output logic               pslverr,
	output fpClassPkg::fpWord  opA,
	output fpClassPkg::fpWord  opB,
	output logic               start,
	input  fpClassPkg::fpClass classA,
	input  fpClassPkg::fpClass classB,
	input  logic               eq,
	input  logic               lt,
	input  logic               unordered,
	input  logic               invalid,
	input  logic               resultValid
);

	fpClassPkg::regSel  sel;
	logic               setupPh;     // psel without penable
	logic               accessPh;    // psel with penable
	logic               readOnly;
	logic               badAccess;
	logic               wrEn;
	fpClassPkg::fpClass classAReg;
	fpClassPkg::fpClass classBReg;
	logic               eqReg;
	logic               ltReg;
	logic               unorderedReg;
	logic               invalidReg;
	logic               doneReg;
	fpClassPkg::fpClass classAView;
	fpClassPkg::fpClass classBView;
	logic [4:0]         statusView;  // invalid, unordered, lt, eq, done
	fpClassPkg::fpWord  rdMux;

	// ==============================
	// decode and error
	// ==============================
	always_comb begin
		case (paddr)
			`REG_OPA:    sel = fpClassPkg::selOpA;
			`REG_OPB:    sel = fpClassPkg::selOpB;
			`REG_CTRL:   sel = fpClassPkg::selCtrl;
			`REG_CLASSA: sel = fpClassPkg::selClassA;
			`REG_CLASSB: sel = fpClassPkg::selClassB;
			`REG_STATUS: sel = fpClassPkg::selStatus;
			default:     sel = fpClassPkg::selNone;
		endcase
	end

	assign setupPh   = psel & ~penable;
	assign accessPh  = psel & penable;
	assign readOnly  = (sel == fpClassPkg::selClassA) | (sel == fpClassPkg::selClassB) |
		(sel == fpClassPkg::selStatus);
	assign badAccess = (sel == fpClassPkg::selNone) | (pwrite & readOnly);
	assign wrEn      = accessPh & pwrite & ~badAccess;  // bad writes change nothing
	assign pslverr   = accessPh & badAccess;
	assign pready    = 1'b1;

	// results bypass the latch during the cycle they arrive
	assign classAView = resultValid ? classA : classAReg;
	assign classBView = resultValid ? classB : classBReg;
	assign statusView = resultValid ? {invalid, unordered, lt, eq, 1'b1} :
		{invalidReg, unorderedReg, ltReg, eqReg, doneReg};

	always_comb begin
		rdMux = '0;  // CTRL and unmapped read as zero
		case (sel)
			fpClassPkg::selOpA:    rdMux = opA;
			fpClassPkg::selOpB:    rdMux = opB;
			fpClassPkg::selClassA: rdMux = {{(`FP_WIDTH-`CLASS_WIDTH){1'b0}}, classAView};
			fpClassPkg::selClassB: rdMux = {{(`FP_WIDTH-`CLASS_WIDTH){1'b0}}, classBView};
			fpClassPkg::selStatus: rdMux = {{(`FP_WIDTH-5){1'b0}}, statusView};
			default:               rdMux = '0;
		endcase
	end

	// ==============================
	// registers
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			opA          <= '0;
			opB          <= '0;
			start        <= 1'b0;
			prdata       <= '0;
			classAReg    <= '0;
			classBReg    <= '0;
			eqReg        <= 1'b0;
			ltReg        <= 1'b0;
			unorderedReg <= 1'b0;
			invalidReg   <= 1'b0;
			doneReg      <= 1'b0;
		end else begin
			start <= 1'b0;  // single cycle pulse
			if (wrEn && sel == fpClassPkg::selOpA)
				opA <= pwdata;
			if (wrEn && sel == fpClassPkg::selOpB)
				opB <= pwdata;
			if (resultValid) begin
				classAReg    <= classA;
				classBReg    <= classB;
				eqReg        <= eq;
				ltReg        <= lt;
				unorderedReg <= unordered;
				invalidReg   <= invalid;
				doneReg      <= 1'b1;
			end
			// a new start wins over an older result landing
			if (wrEn && sel == fpClassPkg::selCtrl && pwdata[0]) begin
				start   <= 1'b1;
				doneReg <= 1'b0;
			end
			if (setupPh && !pwrite)
				prdata <= rdMux;  // held through the access phase
		end
	end

	// APB protocol, no access phase without select
	penableNeedsPsel: assert property (
		@(posedge clk) disable iff (reset)
		penable |-> psel
	);

endmodule

// ==== fpCompare.sv ====
// ==============================
// classify and compare stage
// fclass of both operands and the
// IEEE ordered comparison, one
// register stage behind startIn
// ==============================
`timescale 1ns/1ps
`include "fpClass_defines.svh"

module fpCompare (
	input  logic               clk,
	input  logic               reset,
	input  logic               startIn,
	fpDecompIf.dst             a,
	fpDecompIf.dst             b,
	output fpClassPkg::fpClass classA,
	output fpClassPkg::fpClass classB,
	output logic               eq,
	output logic               lt,
	output logic               unordered,
	output logic               invalid,
	output logic               resultValid
);

	// magnitude as exponent then fraction, orders like an unsigned int
	logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH-1:0] magA;
	logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH-1:0] magB;
	logic magEq;
	logic magLt;
	logic anyNan;
	logic anySnan;
	logic bothZero;
	logic eqNext;
	logic ltNext;

	// one-hot class from the decomposed flags
	function automatic fpClassPkg::fpClass classOf(input logic sgn, input logic xz,
			input logic mz, input logic vz, input logic inf, input logic snan,
			input logic nan);
		fpClassPkg::fpClass c;
		c = '0;
		if (nan)
			c[snan ? 8 : 9] = 1'b1;       // sign ignored for NaNs
		else if (inf)
			c[sgn ? 0 : 7] = 1'b1;
		else if (vz)
			c[sgn ? 3 : 4] = 1'b1;
		else if (xz && !mz)
			c[sgn ? 2 : 5] = 1'b1;        // subnormal
		else
			c[sgn ? 1 : 6] = 1'b1;        // normal
		return c;
	endfunction

	// ==============================
	// ordered comparison
	// ==============================
	assign magA     = {a.exp, a.man};
	assign magB     = {b.exp, b.man};
	assign magEq    = (magA == magB);
	assign magLt    = (magA < magB);
	assign anyNan   = a.nan | b.nan;
	assign anySnan  = a.snan | b.snan;
	assign bothZero = a.vz & b.vz;   // -0 == +0

	assign eqNext = ~anyNan & (bothZero | ((a.sgn == b.sgn) & magEq));
	assign ltNext = ~anyNan & ~bothZero & (
		(a.sgn & ~b.sgn) |                  // negative below positive
		(~a.sgn & ~b.sgn & magLt) |         // both positive
		(a.sgn & b.sgn & ~magEq & ~magLt)   // both negative, larger magnitude is smaller
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			classA      <= '0;
			classB      <= '0;
			eq          <= 1'b0;
			lt          <= 1'b0;
			unordered   <= 1'b0;
			invalid     <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= startIn;  // one cycle behind the stage enable
			if (startIn) begin
				classA    <= classOf(a.sgn, a.xz, a.mz, a.vz, a.inf, a.snan, a.nan);
				classB    <= classOf(b.sgn, b.xz, b.mz, b.vz, b.inf, b.snan, b.nan);
				eq        <= eqNext;
				lt        <= ltNext;
				unordered <= anyNan;
				invalid   <= anySnan;
			end
		end
	end

	// a finished result always carries exactly one class per operand
	classOneHot: assert property (
		@(posedge clk) disable iff (reset)
		resultValid |-> ($onehot(classA) && $onehot(classB))
	);

endmodule

// ==== fpDecompReg.sv ====
// ==============================
// operand decomposition stage
// splits a single-precision word
// into fields and flags, one
// register stage, enabled by ce
// ==============================
`timescale 1ns/1ps
`include "fpClass_defines.svh"

module fpDecompReg (
	input  logic              clk,
	input  logic              reset,
	input  logic              ce,
	input  fpClassPkg::fpWord i,
	fpDecompIf.src            dec
);

	// fields of the incoming word
	logic             iSgn;
	fpClassPkg::fpExp iExp;
	fpClassPkg::fpMan iMan;
	logic             iXz;
	logic             iMz;
	logic             iMaxExp;  // exponent all ones
	logic             iQuietBit;

	assign iSgn      = i[`FP_WIDTH-1];
	assign iExp      = i[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
	assign iMan      = i[`FP_MAN_WIDTH-1:0];
	assign iXz       = ~|iExp;           // zero or subnormal
	assign iMz       = ~|iMan;
	assign iMaxExp   = &iExp;            // inf or NaN
	assign iQuietBit = iMan[`FP_MAN_WIDTH-1]; // top fraction bit marks quiet

	// ==============================
	// register stage
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			dec.sgn  <= 1'b0;
			dec.exp  <= '0;
			dec.man  <= '0;
			dec.xz   <= 1'b0;
			dec.mz   <= 1'b0;
			dec.vz   <= 1'b0;
			dec.inf  <= 1'b0;
			dec.qnan <= 1'b0;
			dec.snan <= 1'b0;
			dec.nan  <= 1'b0;
		end else if (ce) begin
			dec.sgn  <= iSgn;
			dec.exp  <= iExp;
			dec.man  <= iMan;
			dec.xz   <= iXz;
			dec.mz   <= iMz;
			dec.vz   <= iXz & iMz;                // +0 or -0
			dec.inf  <= iMaxExp & iMz;
			dec.qnan <= iMaxExp & iQuietBit;      // quiet bit implies non-zero man
			dec.snan <= iMaxExp & ~iQuietBit & ~iMz;
			dec.nan  <= iMaxExp & ~iMz;
		end
	end

	// special values are exclusive and nan is the union of the two NaN kinds
	specialFlagsConsistent: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0({dec.inf, dec.qnan, dec.snan}) && (dec.nan == (dec.qnan | dec.snan))
	);

endmodule

// ==== fpDecompIf.sv ====
// ==============================
// decomposed operand bundle
// fields and special-value flags
// of one single-precision word
// ==============================
`timescale 1ns/1ps

interface fpDecompIf;

	logic             sgn;   // sign bit
	fpClassPkg::fpExp exp;   // biased exponent
	fpClassPkg::fpMan man;   // fraction field
	logic             xz;    // exponent is zero
	logic             mz;    // mantissa is zero
	logic             vz;    // value is zero, either sign
	logic             inf;   // all ones exponent and zero mantissa
	logic             qnan;  // quiet NaN
	logic             snan;  // signalling NaN
	logic             nan;   // any NaN

	// driven by the decomposition register
	modport src (
		output sgn,
		output exp,
		output man,
		output xz,
		output mz,
		output vz,
		output inf,
		output qnan,
		output snan,
		output nan
	);

	// consumed by the compare stage
	modport dst (
		input sgn,
		input exp,
		input man,
		input xz,
		input mz,
		input vz,
		input inf,
		input qnan,
		input snan,
		input nan
	);

endinterface

// ==== fpClassPkg.sv ====
// ==============================
// fpClass types
// vector typedefs shared by the
// design and the APB decode enum
// ==============================
`include "fpClass_defines.svh"

package fpClassPkg;

	// ==============================
	// data widths
	// ==============================
	typedef logic [`FP_WIDTH-1:0]       fpWord;  // raw IEEE-754 single
	typedef logic [`FP_EXP_WIDTH-1:0]   fpExp;   // biased exponent
	typedef logic [`FP_MAN_WIDTH-1:0]   fpMan;   // stored fraction, no hidden bit

	// one-hot class, bit order
	// 0 -inf, 1 -norm, 2 -subnorm, 3 -0
	// 4 +0, 5 +subnorm, 6 +norm, 7 +inf
	// 8 sNaN, 9 qNaN
	typedef logic [`CLASS_WIDTH-1:0]    fpClass;

	// ==============================
	// bus side
	// ==============================
	typedef logic [`APB_ADDR_WIDTH-1:0] apbAddr;

	// register selected by paddr
	typedef enum logic [2:0] {
		selOpA,
		selOpB,
		selCtrl,
		selClassA,
		selClassB,
		selStatus,
		selNone    // unmapped or unaligned offset
	} regSel;

endpackage

// ==== fpClass_defines.svh ====
// ==============================
// fpClass shared constants
// operand field widths, APB address
// width and the register map
// ==============================
`ifndef FPCLASS_DEFINES_SVH
`define FPCLASS_DEFINES_SVH

// single precision layout
`define FP_WIDTH       32
`define FP_EXP_WIDTH   8
`define FP_MAN_WIDTH   23

`define APB_ADDR_WIDTH 5  // byte address into the register block
`define CLASS_WIDTH    10 // one-hot fclass vector

// register offsets
`define REG_OPA        5'h00 // operand A, rw
`define REG_OPB        5'h04 // operand B, rw
`define REG_CTRL       5'h08 // bit 0 starts, reads 0
`define REG_CLASSA     5'h0C // class of A, ro
`define REG_CLASSB     5'h10 // class of B, ro
`define REG_STATUS     5'h14 // done/eq/lt/unordered/invalid, ro

`endif
